// File: hdl/csr_params.svh
// CSR file parameters
// Addresses of the machine-mode CSRs plus reset and constant values
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN            32
`define CSR_MTVEC_RESET     32'hC000_0000
`define CSR_MISA_VALUE      32'h4000_1106   // RV32 with I, M, C and B

`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MCOUNTIN   12'h320
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344

`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82
`define CSR_ADDR_CYCLE      12'hC00
`define CSR_ADDR_TIME       12'hC01
`define CSR_ADDR_INSTRET    12'hC02
`define CSR_ADDR_CYCLEH     12'hC80
`define CSR_ADDR_TIMEH      12'hC81
`define CSR_ADDR_INSTRETH   12'hC82

`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14

`endif

// File: hdl/csr_pkg.sv
// CSR file package
// Register select, write operation and trap cause types, plus the
// common read-modify-write helper
`default_nettype none

package csr_pkg;

    typedef enum logic [4:0] {
        CSR_MSTATUS, CSR_MISA, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE, CSR_MTVEC,
        CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
        CSR_MCOUNTIN, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
        CSR_CYCLE, CSR_TIME, CSR_INSTRET, CSR_CYCLEH, CSR_TIMEH, CSR_INSTRETH,
        CSR_MCYCLE, CSR_MINSTRET, CSR_MCYCLEH, CSR_MINSTRETH,
        CSR_NONE
    } csr_sel_e;

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_SET   = 2'd1,
        OP_CLEAR = 2'd2
    } csr_op_e;

    // Exception codes accepted in mcause
    typedef enum logic [5:0] {
        TRAP_IALIGN   = 6'd0,
        TRAP_IACCESS  = 6'd1,
        TRAP_IOPCODE  = 6'd2,
        TRAP_BREAKPT  = 6'd3,
        TRAP_LDALIGN  = 6'd4,
        TRAP_LDACCESS = 6'd5,
        TRAP_STALIGN  = 6'd6,
        TRAP_STACCESS = 6'd7,
        TRAP_ECALLM   = 6'd11
    } trap_cause_e;

    function automatic logic [31:0] csr_apply(
        input logic [31:0] old_word,
        input logic [31:0] wdata,
        input csr_op_e     op
    );
        case (op)
            OP_SET:   csr_apply = old_word | wdata;    // csrrs
            OP_CLEAR: csr_apply = old_word & ~wdata;   // csrrc
            default:  csr_apply = wdata;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/csr_write_if.sv
// CSR write bus
// Carries one decoded CSR write from the decoder to the register blocks
`timescale 1ns/1ns
`default_nettype none

interface csr_write_if;

    logic                   wen;    // Write strobe, this cycle only
    csr_pkg::csr_sel_e      sel;    // Target register
    csr_pkg::csr_op_e       op;     // Write, set or clear
    logic [31:0]            wdata;

    modport decoder (output wen, output sel, output op, output wdata);
    modport regfile (input wen, input sel, input op, input wdata);

endinterface

`default_nettype wire

// File: hdl/csr_decode.sv
// CSR address decoder
// Maps the CSR address onto a register select and encodes the write strobes
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module csr_decode (
    input  wire                 g_clk,
    input  wire                 g_resetn,
    input  wire                 csr_en,
    input  wire                 csr_wr,
    input  wire                 csr_wr_set,
    input  wire                 csr_wr_clr,
    input  wire [11:0]          csr_addr,
    input  wire [31:0]          csr_wdata,
    output csr_pkg::csr_sel_e   rd_sel,
    csr_write_if.decoder        wr
);

    csr_pkg::csr_sel_e dec_sel;

    always_comb begin
        case (csr_addr)
            `CSR_ADDR_MSTATUS:   dec_sel = csr_pkg::CSR_MSTATUS;
            `CSR_ADDR_MISA:      dec_sel = csr_pkg::CSR_MISA;
            `CSR_ADDR_MEDELEG:   dec_sel = csr_pkg::CSR_MEDELEG;
            `CSR_ADDR_MIDELEG:   dec_sel = csr_pkg::CSR_MIDELEG;
            `CSR_ADDR_MIE:       dec_sel = csr_pkg::CSR_MIE;
            `CSR_ADDR_MTVEC:     dec_sel = csr_pkg::CSR_MTVEC;
            `CSR_ADDR_MCOUNTIN:  dec_sel = csr_pkg::CSR_MCOUNTIN;
            `CSR_ADDR_MSCRATCH:  dec_sel = csr_pkg::CSR_MSCRATCH;
            `CSR_ADDR_MEPC:      dec_sel = csr_pkg::CSR_MEPC;
            `CSR_ADDR_MCAUSE:    dec_sel = csr_pkg::CSR_MCAUSE;
            `CSR_ADDR_MTVAL:     dec_sel = csr_pkg::CSR_MTVAL;
            `CSR_ADDR_MIP:       dec_sel = csr_pkg::CSR_MIP;
            `CSR_ADDR_MCYCLE:    dec_sel = csr_pkg::CSR_MCYCLE;
            `CSR_ADDR_MINSTRET:  dec_sel = csr_pkg::CSR_MINSTRET;
            `CSR_ADDR_MCYCLEH:   dec_sel = csr_pkg::CSR_MCYCLEH;
            `CSR_ADDR_MINSTRETH: dec_sel = csr_pkg::CSR_MINSTRETH;
            `CSR_ADDR_CYCLE:     dec_sel = csr_pkg::CSR_CYCLE;
            `CSR_ADDR_TIME:      dec_sel = csr_pkg::CSR_TIME;
            `CSR_ADDR_INSTRET:   dec_sel = csr_pkg::CSR_INSTRET;
            `CSR_ADDR_CYCLEH:    dec_sel = csr_pkg::CSR_CYCLEH;
            `CSR_ADDR_TIMEH:     dec_sel = csr_pkg::CSR_TIMEH;
            `CSR_ADDR_INSTRETH:  dec_sel = csr_pkg::CSR_INSTRETH;
            `CSR_ADDR_MVENDORID: dec_sel = csr_pkg::CSR_MVENDORID;
            `CSR_ADDR_MARCHID:   dec_sel = csr_pkg::CSR_MARCHID;
            `CSR_ADDR_MIMPID:    dec_sel = csr_pkg::CSR_MIMPID;
            `CSR_ADDR_MHARTID:   dec_sel = csr_pkg::CSR_MHARTID;
            default:             dec_sel = csr_pkg::CSR_NONE;
        endcase
    end

    assign rd_sel   = csr_en ? dec_sel : csr_pkg::CSR_NONE;

    assign wr.wen   = csr_en && csr_wr;
    assign wr.sel   = dec_sel;
    assign wr.op    = csr_wr_set ? csr_pkg::OP_SET   :
                      csr_wr_clr ? csr_pkg::OP_CLEAR :
                                   csr_pkg::OP_WRITE;   // Set wins if both
    assign wr.wdata = csr_wdata;

    // The core never issues a combined set and clear
    a_set_clr_excl: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (csr_en && csr_wr) |-> !(csr_wr_set && csr_wr_clr));

endmodule

`default_nettype wire

// File: hdl/csr_trap_regs.sv
// Trap CSRs
// Holds mstatus, mtvec, mepc, mcause and mtval. Trap entry and MRET take
// priority over CSR writes to the same registers
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module csr_trap_regs (
    input  wire                     g_clk,
    input  wire                     g_resetn,
    input  wire                     trap_cpu,
    input  wire                     trap_int,
    input  wire [5:0]               trap_cause,
    input  wire [`CSR_XLEN-1:0]     trap_mtval,
    input  wire [`CSR_XLEN-1:0]     trap_pc,
    input  wire                     exec_mret,
    csr_write_if.regfile            wr,
    output logic [31:0]             mstatus_word,
    output logic [31:0]             mtvec_word,
    output logic [31:0]             mepc_word,
    output logic [31:0]             mcause_word,
    output logic [31:0]             mtval_word,
    output logic                    mstatus_mie,
    output logic [`CSR_XLEN-1:0]    csr_mepc,
    output logic [`CSR_XLEN-1:0]    csr_mtvec
);

    localparam logic [31:0] MTVEC_RESET = `CSR_MTVEC_RESET;

    logic        mie_q, mpie_q;
    logic [7:0]  wpri1_q;           // mstatus[30:23]
    logic [1:0]  wpri2_q;           // mstatus[10:9]
    logic        wpri3_q, wpri4_q;  // mstatus[6], mstatus[2]
    logic [29:0] mtvec_base_q;      // Direct mode only
    logic [30:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;
    logic [31:0] mstatus_new, mtvec_new, mepc_new, mcause_new, mtval_new;
    logic        cause_ok;
    wire         trap = trap_cpu || trap_int;

    // -------------------------------------------------------------------------
    // Current words and write results
    // -------------------------------------------------------------------------
    assign mstatus_word = {1'b0, wpri1_q, 12'b0, wpri2_q, 1'b0, mpie_q,
                           wpri3_q, 2'b0, mie_q, wpri4_q, 2'b0};
    assign mtvec_word   = {mtvec_base_q, 2'b00};
    assign mepc_word    = {mepc_q, 1'b0};
    assign mcause_word  = mcause_q;
    assign mtval_word   = mtval_q;
    assign mstatus_mie  = mie_q;
    assign csr_mepc     = mepc_word;
    assign csr_mtvec    = mtvec_word;

    assign mstatus_new = csr_pkg::csr_apply(mstatus_word, wr.wdata, wr.op);
    assign mtvec_new   = csr_pkg::csr_apply(mtvec_word, wr.wdata, wr.op);
    assign mepc_new    = csr_pkg::csr_apply(mepc_word, wr.wdata, wr.op);
    assign mcause_new  = csr_pkg::csr_apply(mcause_word, wr.wdata, wr.op);
    assign mtval_new   = csr_pkg::csr_apply(mtval_word, wr.wdata, wr.op);

    // Only defined exception codes may be written to mcause
    always_comb begin
        case (mcause_new[5:0])
            csr_pkg::TRAP_IALIGN,  csr_pkg::TRAP_IACCESS,
            csr_pkg::TRAP_IOPCODE, csr_pkg::TRAP_BREAKPT,
            csr_pkg::TRAP_LDALIGN, csr_pkg::TRAP_LDACCESS,
            csr_pkg::TRAP_STALIGN, csr_pkg::TRAP_STACCESS,
            csr_pkg::TRAP_ECALLM:  cause_ok = (mcause_new[31:6] == 26'b0);
            default:               cause_ok = 1'b0;
        endcase
    end

    // -------------------------------------------------------------------------
    // Register updates
    // -------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap) begin
            mpie_q <= mie_q;            // Stack the enable
            mie_q  <= 1'b0;
        end else if (exec_mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b0;
        end else if (wr.wen && wr.sel == csr_pkg::CSR_MSTATUS) begin
            mie_q  <= mstatus_new[3];
            mpie_q <= mstatus_new[7];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wpri1_q      <= 8'b0;
            wpri2_q      <= 2'b0;
            wpri3_q      <= 1'b0;
            wpri4_q      <= 1'b0;
            mtvec_base_q <= MTVEC_RESET[31:2];
            mtval_q      <= 32'b0;
        end else begin
            if (wr.wen && wr.sel == csr_pkg::CSR_MSTATUS) begin
                wpri1_q <= mstatus_new[30:23];
                wpri2_q <= mstatus_new[10:9];
                wpri3_q <= mstatus_new[6];
                wpri4_q <= mstatus_new[2];
            end
            if (wr.wen && wr.sel == csr_pkg::CSR_MTVEC)
                mtvec_base_q <= mtvec_new[31:2];
            if (trap_cpu)
                mtval_q <= trap_mtval;  // Interrupts leave mtval alone
            else if (wr.wen && wr.sel == csr_pkg::CSR_MTVAL)
                mtval_q <= mtval_new;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mepc_q   <= 31'b0;
            mcause_q <= 32'b0;
        end else if (trap) begin
            mepc_q   <= trap_pc[31:1];
            mcause_q <= {trap_int, 25'b0, trap_cause};
        end else if (wr.wen) begin
            if (wr.sel == csr_pkg::CSR_MEPC)
                mepc_q <= mepc_new[31:1];
            if (wr.sel == csr_pkg::CSR_MCAUSE && cause_ok)
                mcause_q <= mcause_new;
        end
    end

    // Pipeline retires MRET and takes traps in separate cycles
    a_mret_no_trap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        exec_mret |-> !trap);

endmodule

`default_nettype wire

// File: hdl/csr_ctrl_regs.sv
// Control CSRs
// Holds the mie enables, mscratch and the mcountinhibit bits
`timescale 1ns/1ns
`default_nettype none

module csr_ctrl_regs (
    input  wire             g_clk,
    input  wire             g_resetn,
    csr_write_if.regfile    wr,
    output logic            mie_meie,
    output logic            mie_mtie,
    output logic            mie_msie,
    output logic            inhibit_cy,
    output logic            inhibit_tm,
    output logic            inhibit_ir,
    output logic [31:0]     mscratch_word
);

    logic [31:0] mie_new, mscratch_new, mcountin_new;

    wire [31:0] mie_old = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
    wire [31:0] mcountin_old = {29'b0, inhibit_ir, inhibit_tm, inhibit_cy};

    assign mie_new      = csr_pkg::csr_apply(mie_old, wr.wdata, wr.op);
    assign mscratch_new = csr_pkg::csr_apply(mscratch_word, wr.wdata, wr.op);
    assign mcountin_new = csr_pkg::csr_apply(mcountin_old, wr.wdata, wr.op);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_meie      <= 1'b0;
            mie_mtie      <= 1'b0;
            mie_msie      <= 1'b0;
            mscratch_word <= 32'b0;
            inhibit_cy    <= 1'b0;
            inhibit_tm    <= 1'b0;
            inhibit_ir    <= 1'b0;
        end else if (wr.wen) begin
            if (wr.sel == csr_pkg::CSR_MIE) begin
                mie_meie <= mie_new[11];
                mie_mtie <= mie_new[7];
                mie_msie <= mie_new[3];
            end
            if (wr.sel == csr_pkg::CSR_MSCRATCH)
                mscratch_word <= mscratch_new;
            if (wr.sel == csr_pkg::CSR_MCOUNTIN) begin
                inhibit_cy <= mcountin_new[0];
                inhibit_tm <= mcountin_new[1];
                inhibit_ir <= mcountin_new[2];
            end
        end
    end

    // Interrupts stay masked and counters run once reset is released
    a_reset_clear: assert property (@(posedge g_clk) !g_resetn |=>
        !(mie_meie || mie_mtie || mie_msie || inhibit_cy || inhibit_tm || inhibit_ir));

endmodule

`default_nettype wire

// File: hdl/csr_read_mux.sv
// CSR read multiplexer
// Builds every readable CSR word and returns the selected one, zero if none
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module csr_read_mux (
    input  csr_pkg::csr_sel_e   rd_sel,
    input  wire [31:0]          mstatus_word,
    input  wire [31:0]          mtvec_word,
    input  wire [31:0]          mepc_word,
    input  wire [31:0]          mcause_word,
    input  wire [31:0]          mtval_word,
    input  wire [31:0]          mscratch_word,
    input  wire                 mie_meie,
    input  wire                 mie_mtie,
    input  wire                 mie_msie,
    input  wire                 inhibit_cy,
    input  wire                 inhibit_tm,
    input  wire                 inhibit_ir,
    input  wire                 mip_meip,
    input  wire                 mip_mtip,
    input  wire                 mip_msip,
    input  wire [63:0]          ctr_time,
    input  wire [63:0]          ctr_cycle,
    input  wire [63:0]          ctr_instret,
    output logic [31:0]         csr_rdata
);

    wire [31:0] mie_word = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
    wire [31:0] mip_word = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};
    wire [31:0] mcountin_word = {29'b0, inhibit_ir, inhibit_tm, inhibit_cy};

    always_comb begin
        case (rd_sel)
            csr_pkg::CSR_MSTATUS:   csr_rdata = mstatus_word;
            csr_pkg::CSR_MISA:      csr_rdata = `CSR_MISA_VALUE;
            csr_pkg::CSR_MIE:       csr_rdata = mie_word;
            csr_pkg::CSR_MTVEC:     csr_rdata = mtvec_word;
            csr_pkg::CSR_MCOUNTIN:  csr_rdata = mcountin_word;
            csr_pkg::CSR_MSCRATCH:  csr_rdata = mscratch_word;
            csr_pkg::CSR_MEPC:      csr_rdata = mepc_word;
            csr_pkg::CSR_MCAUSE:    csr_rdata = mcause_word;
            csr_pkg::CSR_MTVAL:     csr_rdata = mtval_word;
            csr_pkg::CSR_MIP:       csr_rdata = mip_word;
            // Machine counters alias the user views
            csr_pkg::CSR_CYCLE,
            csr_pkg::CSR_MCYCLE:    csr_rdata = ctr_cycle[31:0];
            csr_pkg::CSR_CYCLEH,
            csr_pkg::CSR_MCYCLEH:   csr_rdata = ctr_cycle[63:32];
            csr_pkg::CSR_INSTRET,
            csr_pkg::CSR_MINSTRET:  csr_rdata = ctr_instret[31:0];
            csr_pkg::CSR_INSTRETH,
            csr_pkg::CSR_MINSTRETH: csr_rdata = ctr_instret[63:32];
            csr_pkg::CSR_TIME:      csr_rdata = ctr_time[31:0];
            csr_pkg::CSR_TIMEH:     csr_rdata = ctr_time[63:32];
            default:                csr_rdata = 32'b0;  // IDs, delegation, none
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/csr_file_top.sv
// Machine-mode CSR file
// Top level joining the decoder, register blocks and read multiplexer
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module csr_file_top (
    input  wire                     g_clk,
    input  wire                     g_resetn,
    input  wire                     csr_en,
    input  wire                     csr_wr,
    input  wire                     csr_wr_set,
    input  wire                     csr_wr_clr,
    input  wire [11:0]              csr_addr,
    input  wire [`CSR_XLEN-1:0]     csr_wdata,
    output wire [`CSR_XLEN-1:0]     csr_rdata,
    output wire [`CSR_XLEN-1:0]     csr_mepc,
    output wire [`CSR_XLEN-1:0]     csr_mtvec,
    input  wire                     exec_mret,
    output wire                     mstatus_mie,
    output wire                     mie_meie,
    output wire                     mie_mtie,
    output wire                     mie_msie,
    input  wire                     mip_meip,
    input  wire                     mip_mtip,
    input  wire                     mip_msip,
    input  wire [63:0]              ctr_time,
    input  wire [63:0]              ctr_cycle,
    input  wire [63:0]              ctr_instret,
    output wire                     inhibit_cy,
    output wire                     inhibit_tm,
    output wire                     inhibit_ir,
    input  wire                     trap_cpu,
    input  wire                     trap_int,
    input  wire [5:0]               trap_cause,
    input  wire [`CSR_XLEN-1:0]     trap_mtval,
    input  wire [`CSR_XLEN-1:0]     trap_pc
);

    csr_pkg::csr_sel_e  rd_sel;
    wire [31:0]         mstatus_word, mtvec_word, mepc_word;
    wire [31:0]         mcause_word, mtval_word, mscratch_word;

    csr_write_if wr_bus ();

    csr_decode u_decode (
        .g_clk, .g_resetn, .csr_en, .csr_wr, .csr_wr_set, .csr_wr_clr,
        .csr_addr, .csr_wdata, .rd_sel, .wr(wr_bus.decoder)
    );

    csr_trap_regs u_trap_regs (
        .g_clk, .g_resetn, .trap_cpu, .trap_int, .trap_cause, .trap_mtval,
        .trap_pc, .exec_mret, .wr(wr_bus.regfile),
        .mstatus_word, .mtvec_word, .mepc_word, .mcause_word, .mtval_word,
        .mstatus_mie, .csr_mepc, .csr_mtvec
    );

    csr_ctrl_regs u_ctrl_regs (
        .g_clk, .g_resetn, .wr(wr_bus.regfile),
        .mie_meie, .mie_mtie, .mie_msie,
        .inhibit_cy, .inhibit_tm, .inhibit_ir, .mscratch_word
    );

    csr_read_mux u_read_mux (
        .rd_sel, .mstatus_word, .mtvec_word, .mepc_word, .mcause_word,
        .mtval_word, .mscratch_word, .mie_meie, .mie_mtie, .mie_msie,
        .inhibit_cy, .inhibit_tm, .inhibit_ir, .mip_meip, .mip_mtip, .mip_msip,
        .ctr_time, .ctr_cycle, .ctr_instret, .csr_rdata
    );

endmodule

`default_nettype wire

// File: verification/csr_file_tb.sv
// CSR file testbench
// Random CSR accesses, traps and MRET checked cycle by cycle against a
// register model kept in the testbench
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module csr_file_tb;

    localparam int NUM_TXN      = 3000;
    localparam int NUM_ADDRS    = 26;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int TIMEOUT_NS   = (NUM_TXN + NUM_ADDRS + RESET_CYCLES + 10) * CLK_PERIOD;

    localparam logic [31:0] MSTATUS_MASK = 32'h7F80_06CC;  // WPRI, MPIE, MIE
    localparam logic [31:0] MIE_MASK     = 32'h0000_0888;

    logic        g_clk, g_resetn;
    logic        csr_en, csr_wr, csr_wr_set, csr_wr_clr;
    logic [11:0] csr_addr;
    logic [31:0] csr_wdata;
    wire  [31:0] csr_rdata, csr_mepc, csr_mtvec;
    logic        exec_mret;
    wire         mstatus_mie, mie_meie, mie_mtie, mie_msie;
    logic        mip_meip, mip_mtip, mip_msip;
    logic [63:0] ctr_time, ctr_cycle, ctr_instret;
    wire         inhibit_cy, inhibit_tm, inhibit_ir;
    logic        trap_cpu, trap_int;
    logic [5:0]  trap_cause;
    logic [31:0] trap_mtval, trap_pc;

    // Model state
    logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause, m_mtval;
    logic [31:0] m_mscratch, m_mie, m_mcountin;

    logic [31:0] rng_state;
    int          error_count;
    int          check_count;

    logic [11:0] addr_tab [NUM_ADDRS] = '{
        `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MEDELEG, `CSR_ADDR_MIDELEG,
        `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MCOUNTIN, `CSR_ADDR_MSCRATCH,
        `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP,
        `CSR_ADDR_MCYCLE, `CSR_ADDR_MINSTRET, `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRETH,
        `CSR_ADDR_CYCLE, `CSR_ADDR_TIME, `CSR_ADDR_INSTRET, `CSR_ADDR_CYCLEH,
        `CSR_ADDR_TIMEH, `CSR_ADDR_INSTRETH, `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID,
        `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID
    };

    csr_file_top csr_file_top_inst (.*);

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        hi = rng_state[31:16];                  // Upper bits are the good ones
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        next_rand = {hi, rng_state[31:16]};
    endfunction

    function automatic logic [31:0] rmw_result(input logic [31:0] old_word,
                                               input logic [31:0] data);
        if (csr_wr_set)
            rmw_result = old_word | data;
        else if (csr_wr_clr)
            rmw_result = old_word & ~data;
        else
            rmw_result = data;
    endfunction

    function automatic logic cause_legal(input logic [31:0] word);
        cause_legal = (word[31:6] == 26'b0) && (word[5:0] <= 6'd7 || word[5:0] == 6'd11);
    endfunction

    function automatic logic [31:0] expected_read(input logic [11:0] addr, input logic en);
        logic [31:0] mip_w;
        mip_w = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0, mip_msip, 3'b0};
        expected_read = 32'b0;
        if (en) begin
            case (addr)
                `CSR_ADDR_MSTATUS:  expected_read = m_mstatus;
                `CSR_ADDR_MISA:     expected_read = `CSR_MISA_VALUE;
                `CSR_ADDR_MIE:      expected_read = m_mie;
                `CSR_ADDR_MTVEC:    expected_read = m_mtvec;
                `CSR_ADDR_MCOUNTIN: expected_read = m_mcountin;
                `CSR_ADDR_MSCRATCH: expected_read = m_mscratch;
                `CSR_ADDR_MEPC:     expected_read = m_mepc;
                `CSR_ADDR_MCAUSE:   expected_read = m_mcause;
                `CSR_ADDR_MTVAL:    expected_read = m_mtval;
                `CSR_ADDR_MIP:      expected_read = mip_w;
                `CSR_ADDR_CYCLE, `CSR_ADDR_MCYCLE:       expected_read = ctr_cycle[31:0];
                `CSR_ADDR_CYCLEH, `CSR_ADDR_MCYCLEH:     expected_read = ctr_cycle[63:32];
                `CSR_ADDR_INSTRET, `CSR_ADDR_MINSTRET:   expected_read = ctr_instret[31:0];
                `CSR_ADDR_INSTRETH, `CSR_ADDR_MINSTRETH: expected_read = ctr_instret[63:32];
                `CSR_ADDR_TIME:     expected_read = ctr_time[31:0];
                `CSR_ADDR_TIMEH:    expected_read = ctr_time[63:32];
                default:            expected_read = 32'b0;
            endcase
        end
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic set_idle(input logic [11:0] addr);
        csr_en      = 1'b1;
        csr_wr      = 1'b0;
        csr_wr_set  = 1'b0;
        csr_wr_clr  = 1'b0;
        csr_addr    = addr;
        csr_wdata   = 32'b0;
        exec_mret   = 1'b0;
        mip_meip    = 1'b0;
        mip_mtip    = 1'b0;
        mip_msip    = 1'b0;
        ctr_time    = 64'b0;
        ctr_cycle   = 64'b0;
        ctr_instret = 64'b0;
        trap_cpu    = 1'b0;
        trap_int    = 1'b0;
        trap_cause  = 6'b0;
        trap_mtval  = 32'b0;
        trap_pc     = 32'b0;
    endtask

    task automatic drive_random();
        logic [31:0] r, sel, d, m;
        r   = next_rand();
        sel = next_rand();
        d   = next_rand();
        m   = next_rand();
        csr_en      = (r[3:0] != 4'd0);
        csr_addr    = (r[7:4] == 4'd0) ? sel[27:16] : addr_tab[sel[15:0] % NUM_ADDRS];
        csr_wr      = (r[9:8] != 2'd0);
        csr_wr_set  = r[10] & r[11];
        csr_wr_clr  = !csr_wr_set && r[12] && r[13];
        csr_wdata   = r[14] ? {28'b0, d[3:0]} : d;  // Small values reach legal causes
        trap_cpu    = (r[17:15] == 3'd0);
        trap_int    = (r[20:18] == 3'd0);
        exec_mret   = (r[23:21] == 3'd0) && !trap_cpu && !trap_int;
        trap_cause  = r[29:24];
        {mip_meip, mip_mtip, mip_msip} = m[2:0];
        trap_pc     = next_rand();
        trap_mtval  = next_rand();
        ctr_time    = {next_rand(), next_rand()};
        ctr_cycle   = {next_rand(), next_rand()};
        ctr_instret = {next_rand(), next_rand()};
    endtask

    task automatic update_model();
        logic [31:0] ms_old;
        logic [31:0] nw;
        ms_old = m_mstatus;
        if (csr_en && csr_wr) begin
            case (csr_addr)
                `CSR_ADDR_MSTATUS:  m_mstatus  = rmw_result(ms_old, csr_wdata) & MSTATUS_MASK;
                `CSR_ADDR_MIE:      m_mie      = rmw_result(m_mie, csr_wdata) & MIE_MASK;
                `CSR_ADDR_MTVEC:    m_mtvec    = rmw_result(m_mtvec, csr_wdata) & ~32'h3;
                `CSR_ADDR_MCOUNTIN: m_mcountin = rmw_result(m_mcountin, csr_wdata) & 32'h7;
                `CSR_ADDR_MSCRATCH: m_mscratch = rmw_result(m_mscratch, csr_wdata);
                `CSR_ADDR_MEPC:     m_mepc     = rmw_result(m_mepc, csr_wdata) & ~32'h1;
                `CSR_ADDR_MTVAL:    m_mtval    = rmw_result(m_mtval, csr_wdata);
                `CSR_ADDR_MCAUSE: begin
                    nw = rmw_result(m_mcause, csr_wdata);
                    if (cause_legal(nw))
                        m_mcause = nw;
                end
                default: ;                      // Read-only or unknown
            endcase
        end
        // Trap and MRET override the write on the fields they own
        if (trap_cpu || trap_int) begin
            m_mstatus[7] = ms_old[3];
            m_mstatus[3] = 1'b0;
            m_mepc       = {trap_pc[31:1], 1'b0};
            m_mcause     = {trap_int, 25'b0, trap_cause};
            if (trap_cpu)
                m_mtval = trap_mtval;
        end else if (exec_mret) begin
            m_mstatus[3] = ms_old[7];
            m_mstatus[7] = 1'b0;
        end
    endtask

    task automatic check_outputs();
        logic [31:0] exp;
        exp = expected_read(csr_addr, csr_en);
        check_count++;
        assert (csr_rdata === exp)
        else report_mismatch($sformatf("csr_rdata at %h", csr_addr), csr_rdata, exp);
        assert (mstatus_mie === m_mstatus[3])
        else report_mismatch("mstatus_mie", {31'b0, mstatus_mie}, {31'b0, m_mstatus[3]});
        assert ({mie_meie, mie_mtie, mie_msie} === {m_mie[11], m_mie[7], m_mie[3]})
        else report_mismatch("mie enables", {29'b0, mie_meie, mie_mtie, mie_msie},
                             {29'b0, m_mie[11], m_mie[7], m_mie[3]});
        assert ({inhibit_ir, inhibit_tm, inhibit_cy} === m_mcountin[2:0])
        else report_mismatch("inhibits", {29'b0, inhibit_ir, inhibit_tm, inhibit_cy},
                             m_mcountin);
        assert (csr_mepc === m_mepc) else report_mismatch("csr_mepc", csr_mepc, m_mepc);
        assert (csr_mtvec === m_mtvec) else report_mismatch("csr_mtvec", csr_mtvec, m_mtvec);
    endtask

    task automatic run_cycle();
        #(CLK_PERIOD / 4);                      // Let the read path settle
        check_outputs();
        @(posedge g_clk);
        update_model();
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        error_count = 0;
        check_count = 0;
        rng_state   = 32'd35690;
        g_resetn    = 1'b0;
        set_idle(12'h000);
        m_mstatus  = 32'b0;
        m_mtvec    = `CSR_MTVEC_RESET;
        m_mepc     = 32'b0;
        m_mcause   = 32'b0;
        m_mtval    = 32'b0;
        m_mscratch = 32'b0;
        m_mie      = 32'b0;
        m_mcountin = 32'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;

        for (int i = 0; i < NUM_ADDRS; i++) begin   // Reset values
            set_idle(addr_tab[i]);
            run_cycle();
            @(negedge g_clk);
        end

        for (int n = 0; n < NUM_TXN; n++) begin
            drive_random();
            run_cycle();
            @(negedge g_clk);
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns, %0d errors so far",
                 TIMEOUT_NS, error_count);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_write_if.sv
hdl/csr_decode.sv
hdl/csr_trap_regs.sv
hdl/csr_ctrl_regs.sv
hdl/csr_read_mux.sv
hdl/csr_file_top.sv
verification/csr_file_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module csr_file_tb -o csr_file_sim

output=$(./obj_dir/csr_file_sim)
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
